/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int data_w     = 8;            // register and data byte width
    localparam int instr_w    = 9;            // one instruction word
    localparam int pc_w       = 8;            // addresses all of imem
    localparam int imem_depth = 256;          // words of instr_w bits
    localparam int dmem_depth = 256;          // bytes

    localparam logic [instr_w-1:0] halt_word = 9'b010000000; // branch type with zero offset

    // top two bits of the instruction word
    typedef enum logic [1:0] {
        type_r      = 2'b00,
        type_branch = 2'b01,
        type_imm    = 2'b10,
        type_mem    = 2'b11
    } instr_type_e;

    // low eight values line up with the r-type op field [6:4]
    typedef enum logic [3:0] {
        alu_and    = 4'd0,
        alu_add    = 4'd1,
        alu_sub    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_shl    = 4'd5,            // a << b[2:0]
        alu_shr    = 4'd6,            // a >> b[2:0]
        alu_slt    = 4'd7,            // unsigned a < b
        alu_pass_a = 4'd8,            // moves and branch test
        alu_pass_b = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        st_idle = 2'b00,              // waiting for first start
        st_run  = 2'b01,              // one instruction per clock
        st_halt = 2'b10               // done, may restart
    } run_state_e;

endpackage

`default_nettype wire

/* source/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded control for the current instruction
interface ctrl_if (
    input logic clk,                  // only for checks in the decoder
    input logic rst_n
);
    logic [cpu_pkg::instr_w-1:0] instr;   // raw word, immediate and offset come from here
    logic [1:0]                  ra_addr;  // register read port a
    logic [1:0]                  rb_addr;  // register read port b
    logic [1:0]                  wr_addr;  // write-back target
    cpu_pkg::alu_op_e            alu_op;
    logic                        write_en;      // register write
    logic                        mem_read;      // write-back from dmem
    logic                        mem_write;     // store
    logic                        use_immediate; // b = zext(instr[6:0])
    logic                        branch_en;     // branch if r0 == 0
    logic                        halt;

    modport decoder (
        input  clk, rst_n,
        output instr, ra_addr, rb_addr, wr_addr, alu_op,
        output write_en, mem_read, mem_write, use_immediate, branch_en, halt
    );

    modport datapath (
        input  instr, ra_addr, rb_addr, wr_addr, alu_op,
        input  write_en, mem_read, mem_write, use_immediate, branch_en, halt
    );

endinterface

`default_nettype wire

/* source/control_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    input  logic [cpu_pkg::instr_w-1:0] instr,
    ctrl_if.decoder                     ctrl
);

    cpu_pkg::instr_type_e itype;
    logic [2:0]           op_field;       // r-type operation
    logic [1:0]           a_idx;          // r-type operand a
    logic [1:0]           b_idx;          // r-type operand b
    logic                 a_gt_b;         // reserved ordering used for moves

    assign itype    = cpu_pkg::instr_type_e'(instr[8:7]);
    assign op_field = instr[6:4];
    assign a_idx    = instr[3:2];
    assign b_idx    = instr[1:0];
    assign a_gt_b   = (a_idx > b_idx);

    always_comb begin
        ctrl.instr         = instr;
        ctrl.ra_addr       = 2'd0;
        ctrl.rb_addr       = 2'd0;
        ctrl.wr_addr       = 2'd0;
        ctrl.alu_op        = cpu_pkg::alu_pass_a;
        ctrl.write_en      = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.use_immediate = 1'b0;
        ctrl.branch_en     = 1'b0;
        ctrl.halt          = 1'b0;

        case (itype)
            cpu_pkg::type_r: begin
                ctrl.ra_addr  = a_idx;
                ctrl.rb_addr  = b_idx;
                ctrl.wr_addr  = 2'd1;                              // normal results land in r1
                ctrl.alu_op   = cpu_pkg::alu_op_e'({1'b0, op_field});
                ctrl.write_en = 1'b1;
                if (a_gt_b && op_field == 3'd0) begin              // and form, reg a <= reg b
                    ctrl.alu_op  = cpu_pkg::alu_pass_b;
                    ctrl.wr_addr = a_idx;
                end else if (a_gt_b && op_field == 3'd1) begin     // add form, reg b <= reg a
                    ctrl.alu_op  = cpu_pkg::alu_pass_a;
                    ctrl.wr_addr = b_idx;
                end
            end
            cpu_pkg::type_branch: begin
                // r0 goes through pass_a so zero reflects r0
                if (instr == cpu_pkg::halt_word) begin
                    ctrl.halt = 1'b1;
                end else begin
                    ctrl.branch_en = 1'b1;
                end
            end
            cpu_pkg::type_imm: begin
                ctrl.wr_addr       = 2'd1;                         // r1 = r0 + imm
                ctrl.alu_op        = cpu_pkg::alu_add;
                ctrl.use_immediate = 1'b1;
                ctrl.write_en      = 1'b1;
            end
            default: begin                                         // load/store
                ctrl.ra_addr = instr[5:4];                         // data register
                ctrl.rb_addr = instr[3:2];                         // address register
                ctrl.wr_addr = instr[5:4];
                if (instr[6]) begin
                    ctrl.mem_write = 1'b1;
                end else begin
                    ctrl.mem_read  = 1'b1;
                    ctrl.write_en  = 1'b1;                         // reg <= dmem[addr]
                end
            end
        endcase
    end

    a_mem_rw_onehot: assert property (@(posedge ctrl.clk) disable iff (!ctrl.rst_n)
        !(ctrl.mem_read && ctrl.mem_write));

    a_halt_no_write: assert property (@(posedge ctrl.clk) disable iff (!ctrl.rst_n)
        ctrl.halt |-> !ctrl.write_en && !ctrl.mem_write);

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_valid,
    output logic                        start_ready,  // idle or halted
    output logic                        done,
    output logic                        running,      // write gate for regs and dmem
    input  logic                        zero,         // r0 == 0 on branch words
    input  logic                        prog_we,
    input  logic [cpu_pkg::pc_w-1:0]    prog_addr,
    input  logic [cpu_pkg::instr_w-1:0] prog_data,
    output logic [cpu_pkg::instr_w-1:0] instr,
    ctrl_if.datapath                    ctrl
);

    logic [cpu_pkg::instr_w-1:0] imem [cpu_pkg::imem_depth];  // no reset, loaded by prog port
    logic [cpu_pkg::pc_w-1:0]    pc;
    logic [cpu_pkg::pc_w-1:0]    pc_next;
    logic [cpu_pkg::pc_w-1:0]    offset;                      // sign-extended instr[6:0]
    cpu_pkg::run_state_e         state;
    logic                        start_fire;

    assign start_ready = (state == cpu_pkg::st_idle) || (state == cpu_pkg::st_halt);
    assign done        = (state == cpu_pkg::st_halt);
    assign running     = (state == cpu_pkg::st_run);
    assign start_fire  = start_valid && start_ready;
    assign instr       = imem[pc];

    assign offset = {{(cpu_pkg::pc_w-7){ctrl.instr[6]}}, ctrl.instr[6:0]};

    always_comb begin
        pc_next = pc + 1'b1;                                  // wraps at 256
        if (ctrl.branch_en && zero) begin
            pc_next = pc + offset;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we && start_ready) begin                     // ignored while running
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::st_idle;
            pc    <= '0;
        end else begin
            case (state)
                cpu_pkg::st_idle, cpu_pkg::st_halt: begin
                    if (start_fire) begin
                        state <= cpu_pkg::st_run;
                        pc    <= '0;                          // every run starts at 0
                    end
                end
                cpu_pkg::st_run: begin
                    if (ctrl.halt) begin
                        state <= cpu_pkg::st_halt;            // pc holds on halt
                    end else begin
                        pc <= pc_next;
                    end
                end
                default: state <= cpu_pkg::st_idle;
            endcase
        end
    end

    a_run_exit_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
        (state == cpu_pkg::st_run && !ctrl.halt) |=> state == cpu_pkg::st_run);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       running,
    input  logic [cpu_pkg::data_w-1:0] alu_result,
    input  logic [cpu_pkg::data_w-1:0] mem_rdata,
    output logic [cpu_pkg::data_w-1:0] ra_data,
    output logic [cpu_pkg::data_w-1:0] rb_data,
    ctrl_if.datapath                   ctrl
);

    logic [cpu_pkg::data_w-1:0] regs [4];   // r0..r3
    logic [cpu_pkg::data_w-1:0] wr_data;

    assign wr_data = ctrl.mem_read ? mem_rdata : alu_result;   // load vs alu write-back

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (running && ctrl.write_en) begin
            regs[ctrl.wr_addr] <= wr_data;
        end
    end

    // combinational reads so loads finish in one cycle
    assign ra_data = regs[ctrl.ra_addr];
    assign rb_data = regs[ctrl.rb_addr];

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [cpu_pkg::data_w-1:0] ra_data,
    input  logic [cpu_pkg::data_w-1:0] rb_data,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic                       zero,
    ctrl_if.datapath                   ctrl
);

    logic [cpu_pkg::data_w-1:0] op_b;
    logic [2:0]                 shamt;   // shifts use low 3 bits of b

    assign op_b  = ctrl.use_immediate ?
                   {{(cpu_pkg::data_w-7){1'b0}}, ctrl.instr[6:0]} : rb_data;  // zext imm
    assign shamt = op_b[2:0];

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::alu_and:    result = ra_data & op_b;
            cpu_pkg::alu_add:    result = ra_data + op_b;         // mod 256
            cpu_pkg::alu_sub:    result = ra_data - op_b;
            cpu_pkg::alu_or:     result = ra_data | op_b;
            cpu_pkg::alu_xor:    result = ra_data ^ op_b;
            cpu_pkg::alu_shl:    result = ra_data << shamt;
            cpu_pkg::alu_shr:    result = ra_data >> shamt;       // logical
            cpu_pkg::alu_slt:    result = {{(cpu_pkg::data_w-1){1'b0}}, ra_data < op_b};
            cpu_pkg::alu_pass_a: result = ra_data;
            cpu_pkg::alu_pass_b: result = op_b;
            default:             result = '0;
        endcase
    end

    assign zero = (result == '0);   // branch test on pass_a of r0

endmodule

`default_nettype wire

/* source/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                       clk,
    input  logic                       running,
    input  logic [cpu_pkg::data_w-1:0] addr,      // from address register
    input  logic [cpu_pkg::data_w-1:0] wdata,     // from data register
    output logic [cpu_pkg::data_w-1:0] rdata,
    input  logic [cpu_pkg::data_w-1:0] dbg_addr,
    output logic [cpu_pkg::data_w-1:0] dbg_data,
    ctrl_if.datapath                   ctrl
);

    logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::dmem_depth];

    always_ff @(posedge clk) begin
        if (running && ctrl.mem_write) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata    = mem[addr];       // same-cycle load
    assign dbg_data = mem[dbg_addr];   // read-back after done

endmodule

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_valid,
    output logic                        start_ready,
    output logic                        done,
    input  logic                        prog_we,
    input  logic [cpu_pkg::pc_w-1:0]    prog_addr,
    input  logic [cpu_pkg::instr_w-1:0] prog_data,
    input  logic [cpu_pkg::data_w-1:0]  dbg_addr,
    output logic [cpu_pkg::data_w-1:0]  dbg_data
);

    logic [cpu_pkg::instr_w-1:0] instr;
    logic                        running;
    logic                        zero;
    logic [cpu_pkg::data_w-1:0]  ra_data;      // also store data
    logic [cpu_pkg::data_w-1:0]  rb_data;      // also dmem address
    logic [cpu_pkg::data_w-1:0]  alu_result;
    logic [cpu_pkg::data_w-1:0]  mem_rdata;

    ctrl_if u_ctrl_if (.clk(clk), .rst_n(rst_n));

    control_decoder u_control_decoder (
        .instr (instr),
        .ctrl  (u_ctrl_if.decoder)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .done        (done),
        .running     (running),
        .zero        (zero),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .instr       (instr),
        .ctrl        (u_ctrl_if.datapath)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .running    (running),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .ra_data    (ra_data),
        .rb_data    (rb_data),
        .ctrl       (u_ctrl_if.datapath)
    );

    alu u_alu (
        .ra_data (ra_data),
        .rb_data (rb_data),
        .result  (alu_result),
        .zero    (zero),
        .ctrl    (u_ctrl_if.datapath)
    );

    data_mem u_data_mem (
        .clk      (clk),
        .running  (running),
        .addr     (rb_data),
        .wdata    (ra_data),
        .rdata    (mem_rdata),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data),
        .ctrl     (u_ctrl_if.datapath)
    );

endmodule

`default_nettype wire

/* verif/cpu_model.svh */
// reference model, steps prog[] with the isa rules and predicts regs and dmem
logic [7:0] m_regs    [4];
logic [7:0] m_mem     [256];
bit         m_touched [256];     // bytes stored by the current run

task automatic model_reset();
    foreach (m_regs[i]) m_regs[i] = 8'd0;     // regs clear on reset
    foreach (m_mem[i]) begin
        m_mem[i]     = 8'd0;
        m_touched[i] = 1'b0;
    end
endtask

function automatic logic [7:0] model_alu(input logic [2:0] op, input logic [7:0] a,
                                         input logic [7:0] b);
    case (op)
        3'd0:    return a & b;
        3'd1:    return a + b;                // mod 256
        3'd2:    return a - b;
        3'd3:    return a | b;
        3'd4:    return a ^ b;
        3'd5:    return a << b[2:0];
        3'd6:    return a >> b[2:0];
        default: return (a < b) ? 8'd1 : 8'd0; // unsigned compare
    endcase
endfunction

task automatic model_run();
    logic [7:0] pc;
    logic [8:0] w;
    logic [1:0] ia;
    logic [1:0] ib;
    pc = 8'd0;                                // every start begins at 0
    foreach (m_touched[i]) m_touched[i] = 1'b0;
    for (int step = 0; step < 2000; step++) begin
        w  = prog[pc];
        ia = w[3:2];
        ib = w[1:0];
        if (w == 9'b010000000)
            break;                            // halt, nothing written
        case (w[8:7])
            2'b00: begin
                if (w[6:4] == 3'd0 && ia > ib)
                    m_regs[ia] = m_regs[ib];  // and form moves b into a
                else if (w[6:4] == 3'd1 && ia > ib)
                    m_regs[ib] = m_regs[ia];  // add form moves a into b
                else
                    m_regs[1] = model_alu(w[6:4], m_regs[ia], m_regs[ib]);
            end
            2'b01: begin
                if (m_regs[0] == 8'd0)
                    pc = pc + {w[6], w[6:0]} - 8'd1;   // signed offset, +1 below
            end
            2'b10: m_regs[1] = m_regs[0] + {1'b0, w[6:0]};
            default: begin
                if (w[6]) begin
                    m_mem[m_regs[w[3:2]]]     = m_regs[w[5:4]];
                    m_touched[m_regs[w[3:2]]] = 1'b1;
                end else begin
                    m_regs[w[5:4]] = m_mem[m_regs[w[3:2]]];
                end
            end
        endcase
        pc = pc + 8'd1;
    end
endtask

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start_valid;
    logic       start_ready;
    logic       done;
    logic       prog_we;
    logic [7:0] prog_addr;
    logic [8:0] prog_data;
    logic [7:0] dbg_addr;
    logic [7:0] dbg_data;

    logic [8:0]  prog [$];           // program being built
    logic [31:0] seed = 32'd16;
    logic [7:0]  exp_byte;
    logic        check_en;
    logic        fresh;              // out of reset, no start yet
    logic        busy;               // accepted start until done
    int          fails = 0;

    `include "cpu_model.svh"

    cpu_top u_cpu_top (.*);

    always #20 clk = ~clk;

    task automatic fail_stop(input string why);
        fails++;
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    a_dbg_byte: assert property (@(posedge clk) check_en |-> dbg_data === exp_byte)
        else fail_stop($sformatf("mismatch at %0t: dmem[%0d] read %02h, expected %02h",
                                 $time, $sampled(dbg_addr), $sampled(dbg_data),
                                 $sampled(exp_byte)));
    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        fresh |-> start_ready && !done)
        else fail_stop("after reset start_ready was low or done was high");
    a_busy_blocks: assert property (@(posedge clk) busy |-> !start_ready)
        else fail_stop("start_ready was high while a program was running");
    a_done_ready: assert property (@(posedge clk) done |-> start_ready)
        else fail_stop("done was high but start_ready was low");

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [7:0] rand8();
        seed = xorshift(seed);
        return seed[7:0];
    endfunction

    function automatic logic [8:0] r_op(input logic [2:0] op, input logic [1:0] a,
                                        input logic [1:0] b);
        return {2'b00, op, a, b};
    endfunction

    task automatic imm(input logic [6:0] v);
        prog.push_back({2'b10, v});                       // r1 = r0 + v
    endtask

    task automatic mem_op(input logic wr, input logic [1:0] rd, input logic [1:0] ra);
        prog.push_back({2'b11, wr, rd, ra, 2'b00});
    endtask

    task automatic move(input logic [1:0] dst, input logic [1:0] src);
        if (dst > src)
            prog.push_back(r_op(3'd0, dst, src));         // and form
        else
            prog.push_back(r_op(3'd1, src, dst));         // add form
    endtask

    // loads any byte into rd and clobbers r0 and r1
    task automatic set_reg(input logic [1:0] rd, input logic [7:0] v);
        prog.push_back(r_op(3'd2, 2'd0, 2'd0));           // r1 = 0
        move(2'd0, 2'd1);
        imm(v[7:1]);
        move(2'd0, 2'd1);
        prog.push_back(r_op(3'd1, 2'd0, 2'd0));           // r1 = 2 * r0
        move(2'd0, 2'd1);
        imm({6'd0, v[0]});
        if (rd != 2'd1)
            move(rd, 2'd1);
    endtask

    task automatic store_at(input logic [1:0] rs, input logic [7:0] addr);
        logic [1:0] rd;
        logic [1:0] ra;
        rd = rs;
        if (rs < 2'd2) begin
            move(2'd2, rs);                               // out of the scratch regs
            rd = 2'd2;
        end
        ra = (rd == 2'd3) ? 2'd2 : 2'd3;
        set_reg(ra, addr);
        mem_op(1'b1, rd, ra);
    endtask

    task automatic sweep();
        for (int a = 0; a < 256; a++) begin
            if (m_touched[a]) begin
                dbg_addr = 8'(a);
                exp_byte = m_mem[a];
                check_en = 1'b1;
                @(posedge clk);
                #2;
            end
        end
        check_en = 1'b0;
    endtask

    // halt, load, start, wait for done, read back
    task automatic run_built(input bit scribble);
        int n;
        prog.push_back(cpu_pkg::halt_word);
        foreach (prog[i]) begin
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = prog[i];
            @(posedge clk);
            #2;
        end
        prog_we = 1'b0;
        model_run();
        fresh       = 1'b0;
        start_valid = 1'b1;
        n = 0;
        while (!start_ready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > 50)
                fail_stop("start handshake was not accepted within 50 cycles");
        end
        @(posedge clk);                                   // handshake edge
        #2;
        start_valid = 1'b0;
        busy        = 1'b1;
        n = 0;
        while (!done) begin
            if (n >= 2000)
                fail_stop("done did not rise within 2000 cycles");
            prog_we   = scribble;                         // halt over the word just run
            prog_addr = 8'(n);
            prog_data = cpu_pkg::halt_word;
            @(posedge clk);
            #2;
            n++;
        end
        prog_we = 1'b0;
        busy    = 1'b0;
        sweep();
    endtask

    initial begin
        logic [7:0] v;
        logic [7:0] w;
        int         loop_top;
        rst_n       = 1'b0;
        start_valid = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = 8'd0;
        prog_data   = 9'd0;
        dbg_addr    = 8'd0;
        exp_byte    = 8'd0;
        check_en    = 1'b0;
        fresh       = 1'b1;
        busy        = 1'b0;
        model_reset();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        prog.delete();                                    // clear dmem, then every r-type op
        set_reg(2'd3, 8'd1);
        set_reg(2'd2, 8'd0);                              // r0 = 0 as store data
        loop_top = prog.size();
        mem_op(1'b1, 2'd0, 2'd2);                         // dmem[r2] = 0
        prog.push_back(r_op(3'd1, 2'd2, 2'd3));
        move(2'd2, 2'd1);                                 // r2 += 1
        prog.push_back(r_op(3'd7, 2'd2, 2'd3));           // r1 = (r2 == 0)
        move(2'd0, 2'd1);
        prog.push_back({2'b01, 7'(loop_top - prog.size())});  // until r2 wraps
        for (int op = 0; op < 8; op++) begin
            set_reg(2'd2, rand8());
            set_reg(2'd3, rand8());
            prog.push_back(r_op(3'(op), 2'd2, 2'd3));
            store_at(2'd1, 8'(8'h10 + op));
        end
        run_built(1'b0);

        prog.delete();                                    // immediates, then store and load
        for (int k = 0; k < 4; k++) begin
            v = rand8();
            w = rand8();
            if (k == 0) begin
                v = 8'hf0;                                // forces the wrap
                w = 8'h7f;
            end
            set_reg(2'd0, v);
            imm(w[6:0]);
            store_at(2'd1, 8'(8'h30 + k));
            set_reg(2'd2, rand8());
            set_reg(2'd3, 8'(8'h40 + k));
            mem_op(1'b1, 2'd2, 2'd3);
        end
        for (int k = 0; k < 4; k++) begin
            set_reg(2'd2, 8'(8'h40 + k));
            mem_op(1'b0, 2'd3, 2'd2);                     // r3 = dmem[r2]
            store_at(2'd3, 8'(8'h50 + k));
        end
        run_built(1'b0);

        prog.delete();                                    // all twelve moves
        for (int d = 0; d < 4; d++) begin
            for (int s = 0; s < 4; s++) begin
                if (d != s) begin
                    v = rand8() | 8'h01;                  // odd so set_reg leaves r0 at v - 1
                    set_reg(2'(s), v);
                    if (d == 1)
                        prog.push_back(r_op(3'd2, 2'(s), 2'(s)));  // r1 = 0 before the move
                    move(2'(d), 2'(s));
                    store_at(2'(d), 8'(8'h20 + 4 * d + s));
                end
            end
        end
        run_built(1'b0);

        prog.delete();                                    // branch taken, not taken, loop
        set_reg(2'd2, 8'haa);
        for (int k = 0; k < 2; k++) begin
            set_reg(2'd3, 8'(8'h60 + k));
            mem_op(1'b1, 2'd3, 2'd3);                     // slot holds its own address
            prog.push_back(r_op(3'd2, 2'd0, 2'd0));
            move(2'd0, 2'd1);                             // r0 = 0
            if (k == 1) begin
                imm(7'd5);
                move(2'd0, 2'd1);                         // r0 = 5
            end
            prog.push_back({2'b01, 7'd2});                // over the store when r0 is 0
            mem_op(1'b1, 2'd2, 2'd3);
        end
        v = rand8();
        set_reg(2'd3, 8'd1);
        set_reg(2'd2, 8'd4 + {5'd0, v[2:0]});             // loop count
        loop_top = prog.size();
        mem_op(1'b1, 2'd2, 2'd2);                         // dmem[r2] = r2
        prog.push_back(r_op(3'd2, 2'd2, 2'd3));
        move(2'd2, 2'd1);                                 // r2 -= 1
        prog.push_back(r_op(3'd7, 2'd2, 2'd3));           // r1 = (r2 == 0)
        move(2'd0, 2'd1);
        prog.push_back({2'b01, 7'(loop_top - prog.size())});
        run_built(1'b1);                                  // prog_we pulses while running

        if (fails == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_stop("one or more checks failed");
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+verif
source/cpu_pkg.sv
source/ctrl_if.sv
source/control_decoder.sv
source/fetch_unit.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/cpu_top.sv
verif/cpu_tb.sv
